//--- design/sram_test_defines.svh
`ifndef SRAM_TEST_DEFINES_SVH
`define SRAM_TEST_DEFINES_SVH

// sram geometry
// 6 address bits keep a full test short, 20 matches the real part
`define SRAM_ADDR_BITS 6
`define SRAM_DATA_BITS 16

// zeros, ones, checker, inverse checker, address
`define SRAM_PATTERNS 5

`endif

//--- design/sram_test_pkg.sv
`include "sram_test_defines.svh"

package sram_test_pkg;

  // one access handed to the sram controller
  // start is a single-cycle pulse
  typedef struct packed {
    logic                       start;
    logic                       write;
    logic [`SRAM_ADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BITS-1:0] wdata;
  } sram_req_t;

  // order matters, pattern_gen steps through these by index
  typedef enum logic [2:0] {
    pat_zeros       = 3'd0,
    pat_ones        = 3'd1,
    pat_checker     = 3'd2,
    pat_checker_inv = 3'd3,
    pat_address     = 3'd4
  } pattern_e;

  // sequencer states
  typedef enum logic [2:0] {
    st_start      = 3'd0,
    st_writing    = 3'd1,
    st_write_hold = 3'd2,
    st_reading    = 3'd3,
    st_read_hold  = 3'd4,
    st_done       = 3'd5,
    st_halt       = 3'd6
  } tester_state_e;

endpackage

//--- design/addr_iter.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module addr_iter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       step,
  output logic [`SRAM_ADDR_BITS-1:0] addr,
  output logic                       last
);

  // wraps to zero after the top address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      addr <= '0;
    end else if (step) begin
      addr <= addr + 1'b1;
    end
  end

  // high while sitting on the final address
  assign last = &addr;

endmodule

//--- design/pattern_gen.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module pattern_gen
  import sram_test_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       restart,
  input  logic                       advance,
  input  logic [`SRAM_ADDR_BITS-1:0] addr,
  output logic [`SRAM_DATA_BITS-1:0] word,
  output pattern_e                   kind,
  output logic                       last
);

  localparam int idx_bits = $clog2(`SRAM_PATTERNS);

  // 0x5555 style word, bit 0 set
  function automatic logic [`SRAM_DATA_BITS-1:0] alt_bits();
    logic [`SRAM_DATA_BITS-1:0] w;
    for (int i = 0; i < `SRAM_DATA_BITS; i++) begin
      w[i] = (i % 2 == 0);
    end
    return w;
  endfunction

  localparam logic [`SRAM_DATA_BITS-1:0] checker_word = alt_bits();

  logic [idx_bits-1:0] pat_idx;

  // pattern index, restart has priority over advance
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pat_idx <= '0;
    end else if (restart) begin
      pat_idx <= '0;
    end else if (advance && !last) begin
      pat_idx <= pat_idx + 1'b1;
    end
  end

  assign kind = pattern_e'(pat_idx);
  assign last = (pat_idx == idx_bits'(`SRAM_PATTERNS - 1));

  // data word for the current address
  always_comb begin
    case (kind)
      pat_zeros: begin
        word = '0;
      end
      pat_ones: begin
        word = '1;
      end
      pat_checker: begin
        word = checker_word;
      end
      pat_checker_inv: begin
        word = ~checker_word;
      end
      pat_address: begin
        // address in the low bits, zero above
        word = `SRAM_DATA_BITS'(addr);
      end
      default: begin
        word = '0;
      end
    endcase
  end

endmodule

//--- design/sram_ctrl.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module sram_ctrl
  import sram_test_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  sram_req_t                  req,
  output logic [`SRAM_DATA_BITS-1:0] rdata,
  output logic                       rd_valid,
  output logic [`SRAM_ADDR_BITS-1:0] io_addr,
  inout  wire  [`SRAM_DATA_BITS-1:0] io_data,
  output logic                       io_we_n,
  output logic                       io_oe_n,
  output logic                       io_ce_n
);

  logic                       drive;
  logic [`SRAM_DATA_BITS-1:0] wdata_q;

  // strobes for the active cycle right after start
  // everything drops back to idle unless another start arrives
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      io_ce_n <= 1'b1;
      io_we_n <= 1'b1;
      io_oe_n <= 1'b1;
      drive   <= 1'b0;
    end else begin
      io_ce_n <= ~req.start;
      io_we_n <= ~(req.start & req.write);
      io_oe_n <= ~(req.start & ~req.write);
      drive   <= req.start & req.write;
    end
  end

  // address held for the whole active cycle
  always_ff @(posedge clk) begin
    if (req.start) begin
      io_addr <= req.addr;
    end
  end

  // write data only changes on a write request
  always_ff @(posedge clk) begin
    if (req.start && req.write) begin
      wdata_q <= req.wdata;
    end
  end

  // bus released except during a write
  assign io_data = drive ? wdata_q : 'z;

  // sample at the end of the read's active cycle
  always_ff @(posedge clk) begin
    if (!io_oe_n) begin
      rdata <= io_data;
    end
  end

  // read valid lines up with the captured word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= ~io_oe_n;
    end
  end

endmodule

//--- design/sram_tester.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module sram_tester
  import sram_test_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  output logic                       test_done,
  output logic                       test_pass,
  output pattern_e                   pattern_state,
  output logic [`SRAM_DATA_BITS-1:0] prev_read_data,
  output logic [`SRAM_DATA_BITS-1:0] prev_expected_data,
  output logic [`SRAM_ADDR_BITS-1:0] io_addr,
  inout  wire  [`SRAM_DATA_BITS-1:0] io_data,
  output logic                       io_we_n,
  output logic                       io_oe_n,
  output logic                       io_ce_n
);

  tester_state_e state;
  tester_state_e next_state;

  sram_req_t req;
  logic      issue;

  logic [`SRAM_ADDR_BITS-1:0] addr;
  logic                       addr_last;
  logic                       addr_step;

  logic [`SRAM_DATA_BITS-1:0] pat_word;
  logic                       pat_last;
  logic                       pat_advance;
  logic                       pat_restart;

  logic [`SRAM_DATA_BITS-1:0] rdata;
  logic                       rd_valid;

  // expected words for reads in flight
  logic [`SRAM_DATA_BITS-1:0] exp_mem [2];
  logic                       exp_wr_ptr;
  logic                       exp_rd_ptr;

  logic check_q;
  logic mismatch;

  addr_iter addr_iter_i (
    .clk   (clk),
    .reset (reset),
    .step  (addr_step),
    .addr  (addr),
    .last  (addr_last)
  );

  pattern_gen pattern_gen_i (
    .clk     (clk),
    .reset   (reset),
    .restart (pat_restart),
    .advance (pat_advance),
    .addr    (addr),
    .word    (pat_word),
    .kind    (pattern_state),
    .last    (pat_last)
  );

  sram_ctrl sram_ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .rdata    (rdata),
    .rd_valid (rd_valid),
    .io_addr  (io_addr),
    .io_data  (io_data),
    .io_we_n  (io_we_n),
    .io_oe_n  (io_oe_n),
    .io_ce_n  (io_ce_n)
  );

  // next state and per-state strobes
  always_comb begin
    next_state  = state;
    addr_step   = 1'b0;
    pat_advance = 1'b0;
    pat_restart = 1'b0;
    case (state)
      st_start: begin
        next_state = st_writing;
      end
      st_writing: begin
        next_state = st_write_hold;
      end
      st_write_hold: begin
        addr_step  = 1'b1;
        next_state = addr_last ? st_reading : st_writing;
      end
      st_reading: begin
        next_state = st_read_hold;
      end
      st_read_hold: begin
        addr_step = 1'b1;
        if (!addr_last) begin
          next_state = st_reading;
        end else if (pat_last) begin
          next_state = st_done;
        end else begin
          pat_advance = 1'b1;
          next_state  = st_writing;
        end
      end
      st_done: begin
        // back to zeros for the next round
        pat_restart = 1'b1;
        next_state  = st_start;
      end
      st_halt: begin
        next_state = st_halt;
      end
      default: begin
        next_state = st_start;
      end
    endcase
  end

  // a detected mismatch overrides the normal flow
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_start;
    end else if (mismatch) begin
      state <= st_halt;
    end else begin
      state <= next_state;
    end
  end

  // one access per writing or reading state
  assign issue = (state == st_writing || state == st_reading);

  always_comb begin
    req.start = issue;
    req.write = (state == st_writing);
    req.addr  = addr;
    req.wdata = pat_word;
  end

  // push on read issue, pop on rd_valid
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exp_wr_ptr <= 1'b0;
      exp_rd_ptr <= 1'b0;
    end else begin
      if (issue && !req.write) begin
        exp_wr_ptr <= ~exp_wr_ptr;
      end
      if (rd_valid) begin
        exp_rd_ptr <= ~exp_rd_ptr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !req.write) begin
      exp_mem[exp_wr_ptr] <= pat_word;
    end
  end

  // debug copies of the last read and its expected word
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      prev_read_data     <= rdata;
      prev_expected_data <= exp_mem[exp_rd_ptr];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      check_q <= 1'b0;
    end else begin
      check_q <= rd_valid;
    end
  end

  // compare one cycle after capture
  assign mismatch = check_q && (prev_read_data != prev_expected_data);

  // sticky pass flag
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_pass <= 1'b1;
    end else if (mismatch) begin
      test_pass <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      test_done <= 1'b0;
    end else begin
      test_done <= (state == st_done);
    end
  end

endmodule

//--- bench/sram_model.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module sram_model (
  input  logic [`SRAM_ADDR_BITS-1:0]         addr,
  inout  wire  [`SRAM_DATA_BITS-1:0]         data,
  input  logic                               we_n,
  input  logic                               oe_n,
  input  logic                               ce_n,
  input  logic                               fault_en,
  input  logic [`SRAM_ADDR_BITS-1:0]         fault_addr,
  input  logic [$clog2(`SRAM_DATA_BITS)-1:0] fault_bit,
  input  logic                               fault_value
);

  localparam int depth = 1 << `SRAM_ADDR_BITS;

  logic [`SRAM_DATA_BITS-1:0] mem [depth];
  logic [`SRAM_DATA_BITS-1:0] rd_word;

  // power-up contents, every word different
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = `SRAM_DATA_BITS'(i * 16'h9e37) ^ 16'h3c5a;
    end
  end

  // write is transparent while ce_n and we_n are both low
  // ignore the bus turning around as we_n rises
  always @(addr or data or we_n or ce_n) begin
    if (!ce_n && !we_n && !$isunknown(data)) begin
      mem[addr] = data;
    end
  end

  // stuck bit only shows up on the read side
  always_comb begin
    rd_word = mem[addr];
    if (fault_en && addr == fault_addr) begin
      rd_word[fault_bit] = fault_value;
    end
  end

  assign data = (!ce_n && !oe_n && we_n) ? rd_word : 'z;

endmodule

//--- bench/tb_sram_tester.sv
`timescale 1ns/1ns

`include "sram_test_defines.svh"

module tb_sram_tester
  import sram_test_pkg::*;
();

  localparam int clk_period  = 100;
  localparam int test_cycles = 4 * (1 << `SRAM_ADDR_BITS) * `SRAM_PATTERNS + 16;
  localparam int hold_cycles = 2 * (1 << `SRAM_ADDR_BITS);

  logic clk;
  logic reset;

  logic                               test_done;
  logic                               test_pass;
  pattern_e                           pattern_state;
  logic [`SRAM_DATA_BITS-1:0]         prev_read_data;
  logic [`SRAM_DATA_BITS-1:0]         prev_expected_data;
  logic [`SRAM_ADDR_BITS-1:0]         io_addr;
  wire  [`SRAM_DATA_BITS-1:0]         io_data;
  logic                               io_we_n;
  logic                               io_oe_n;
  logic                               io_ce_n;

  logic                               fault_en;
  logic [`SRAM_ADDR_BITS-1:0]         fault_addr;
  logic [$clog2(`SRAM_DATA_BITS)-1:0] fault_bit;
  logic                               fault_value;

  integer   seed;
  integer   rnd;
  int       done_count;
  logic     reset_q;
  logic     halted;
  logic     last_was_read;
  pattern_e pat_q;

  sram_tester dut_i (
    .clk                (clk),
    .reset              (reset),
    .test_done          (test_done),
    .test_pass          (test_pass),
    .pattern_state      (pattern_state),
    .prev_read_data     (prev_read_data),
    .prev_expected_data (prev_expected_data),
    .io_addr            (io_addr),
    .io_data            (io_data),
    .io_we_n            (io_we_n),
    .io_oe_n            (io_oe_n),
    .io_ce_n            (io_ce_n)
  );

  sram_model sram_i (
    .addr        (io_addr),
    .data        (io_data),
    .we_n        (io_we_n),
    .oe_n        (io_oe_n),
    .ce_n        (io_ce_n),
    .fault_en    (fault_en),
    .fault_addr  (fault_addr),
    .fault_bit   (fault_bit),
    .fault_value (fault_value)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      stop_on_error($sformatf("FAILED at %0t ns: %s expected %0h, actual %0h",
                              $time, name, expected, actual));
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else
      stop_on_error($sformatf("at %0t ns: %s", $time, what));
  endtask

  // data words as the pattern definitions give them
  function automatic logic [`SRAM_DATA_BITS-1:0] pattern_word(
      input pattern_e kind, input logic [`SRAM_ADDR_BITS-1:0] a);
    case (kind)
      pat_zeros:       return '0;
      pat_ones:        return '1;
      pat_checker:     return {(`SRAM_DATA_BITS / 2){2'b01}};
      pat_checker_inv: return {(`SRAM_DATA_BITS / 2){2'b10}};
      pat_address:     return `SRAM_DATA_BITS'(a);
      default:         return 'x;
    endcase
  endfunction

  function automatic pattern_e next_pattern(input pattern_e kind);
    case (kind)
      pat_zeros:       return pat_ones;
      pat_ones:        return pat_checker;
      pat_checker:     return pat_checker_inv;
      pat_checker_inv: return pat_address;
      default:         return pat_zeros;
    endcase
  endfunction

  // sample at the rising edge, before the DUT registers update
  always @(posedge clk) begin
    if (reset || reset_q) begin
      check_equal("io_we_n", 1, io_we_n);
      check_equal("io_oe_n", 1, io_oe_n);
      check_equal("io_ce_n", 1, io_ce_n);
      check_equal("test_done", 0, test_done);
      check_equal("test_pass", 1, test_pass);
    end
    if (reset) begin
      pat_q         = pat_zeros;
      last_was_read = 1'b0;
      halted        = 1'b0;
    end else begin
      if (io_we_n === 1'b0) begin
        check_equal("io_data", pattern_word(pattern_state, io_addr), io_data);
      end
      if (pattern_state !== pat_q) begin
        check_equal("pattern_state", next_pattern(pat_q), pattern_state);
        check_true(last_was_read, "pattern changed outside a read to write boundary");
        pat_q = pattern_state;
      end
      if (io_oe_n === 1'b0) begin
        last_was_read = 1'b1;
      end
      if (io_we_n === 1'b0) begin
        last_was_read = 1'b0;
      end
      if (!fault_en) begin
        check_equal("test_pass", 1, test_pass);
        if (test_done === 1'b1) begin
          done_count++;
        end
      end else begin
        check_equal("test_done", 0, test_done);
        if (!halted && test_pass === 1'b0) begin
          // the failing pair is still on the debug ports
          check_equal("prev_read_data ^ prev_expected_data", 32'(1) << fault_bit,
                      prev_read_data ^ prev_expected_data);
          halted = 1'b1;
        end
        if (halted) begin
          check_equal("test_pass", 0, test_pass);
          check_equal("io_we_n", 1, io_we_n);
          check_equal("io_oe_n", 1, io_oe_n);
          check_equal("io_ce_n", 1, io_ce_n);
        end
      end
    end
    reset_q = reset;
  end

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  initial begin
    seed        = 32'h00a0_52c2;
    reset       = 1'b1;
    reset_q     = 1'b1;
    fault_en    = 1'b0;
    fault_addr  = '0;
    fault_bit   = '0;
    fault_value = 1'b0;
    done_count  = 0;
    halted      = 1'b0;
    apply_reset();

    // fault-free, two complete rounds
    wait (done_count == 2);
    @(negedge clk);

    // stuck bit at a random place
    rnd         = $random(seed);
    fault_addr  = rnd[`SRAM_ADDR_BITS-1:0];
    rnd         = $random(seed);
    fault_bit   = $unsigned(rnd) % `SRAM_DATA_BITS;
    rnd         = $random(seed);
    fault_value = rnd[0];
    fault_en    = 1'b1;
    apply_reset();

    wait (halted == 1'b1);
    repeat (hold_cycles) @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // three full test lengths cover both runs
  initial begin
    #(3 * test_cycles * clk_period);
    stop_on_error("timeout: the test sequence did not complete in time");
  end

endmodule

//--- compile.f
+incdir+design
design/sram_test_pkg.sv
design/addr_iter.sv
design/pattern_gen.sv
design/sram_ctrl.sv
design/sram_tester.sv
bench/sram_model.sv
bench/tb_sram_tester.sv
